// ==== source/lsq_defs.svh ====
`ifndef LSQ_DEFS_SVH
`define LSQ_DEFS_SVH

// width of a load address in bits.
`define LSQ_ADDR_W 32

// width of the data returned by a load.
`define LSQ_DATA_W 32

// default number of queue slots.
// must stay a power of two, since slot tags are taken straight from the counters.
`define LSQ_DEPTH 8

`endif

// ==== source/lsq_pkg.sv ====
`include "lsq_defs.svh"

package lsq_pkg;

    typedef logic [`LSQ_ADDR_W-1:0] lsq_addr_t;
    typedef logic [`LSQ_DATA_W-1:0] lsq_data_t;

    // slot index, and a counter with one extra wrap bit above it.
    typedef logic [$clog2(`LSQ_DEPTH)-1:0] lsq_tag_t;
    typedef logic [$clog2(`LSQ_DEPTH):0] lsq_ctr_t;

    // busy marks an allocated slot, done marks that memory has returned its data.
    typedef struct packed {
        logic      busy;
        logic      done;
        lsq_addr_t addr;
        lsq_data_t data;
    } lsq_entry_t;

    typedef enum logic {
        idle,
        emit
    } retire_state_t;

endpackage

// ==== source/lsq_queue.sv ====
`timescale 1ns/10ps
`include "lsq_defs.svh"

module lsq_queue
    import lsq_pkg::*;
#(
    parameter int unsigned depth = `LSQ_DEPTH
) (
    input  logic                   clk,
    input  logic                   init,
    input  logic                   flush,
    input  logic                   enq_valid,
    input  lsq_entry_t             enq_data,
    output logic                   enq_ready,
    output lsq_tag_t               enq_tag,
    input  logic                   deq_valid,
    output lsq_entry_t             deq_data,
    input  logic [depth-1:0]       wr_en,
    input  lsq_entry_t [depth-1:0] wr_data,
    output lsq_entry_t [depth-1:0] entries
);
    localparam int unsigned ptr_w = $clog2(depth);

    lsq_entry_t [depth-1:0] slots;
    lsq_ctr_t               enq_ctr;
    lsq_ctr_t               deq_ctr;
    logic [ptr_w-1:0]       enq_ptr;
    logic [ptr_w-1:0]       deq_ptr;
    logic                   full;
    logic                   empty;
    logic                   enq_fire;
    logic                   deq_fire;

    // the counters run over twice the depth, so a shallower queue still wraps correctly.
    function automatic lsq_ctr_t ctr_next(input lsq_ctr_t ctr);
        if (ctr == lsq_ctr_t'(2 * depth - 1)) begin
            return '0;
        end
        return ctr + 1'b1;
    endfunction

    assign enq_ptr = enq_ctr[ptr_w-1:0];
    assign deq_ptr = deq_ctr[ptr_w-1:0];

    // equal pointers mean full when the wrap bits differ and empty when they agree.
    assign empty = (enq_ctr[ptr_w] == deq_ctr[ptr_w]) && (enq_ptr == deq_ptr);
    assign full  = (enq_ctr[ptr_w] != deq_ctr[ptr_w]) && (enq_ptr == deq_ptr);

    assign enq_ready = !full;
    assign enq_fire  = enq_valid && !full;
    assign deq_fire  = deq_valid && !empty;
    assign enq_tag   = lsq_tag_t'(enq_ptr);
    assign deq_data  = slots[deq_ptr];
    assign entries   = slots;

    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            slots   <= '0;
            enq_ctr <= '0;
            deq_ctr <= '0;
        end else if (flush) begin
            slots   <= '0;
            enq_ctr <= '0;
            deq_ctr <= '0;
        end else begin
            if (deq_fire) begin
                slots[deq_ptr] <= '0;
            end
            if (enq_fire) begin
                slots[enq_ptr] <= enq_data;
            end
            // writes only reach busy slots, so they never collide with the enqueue slot.
            for (int i = 0; i < depth; i++) begin
                if (wr_en[i]) begin
                    slots[i] <= wr_data[i];
                end
            end
            if (enq_fire) begin
                enq_ctr <= ctr_next(enq_ctr);
            end
            if (deq_fire) begin
                deq_ctr <= ctr_next(deq_ctr);
            end
        end
    end

endmodule

// ==== source/lsq_dispatch.sv ====
`timescale 1ns/10ps

module lsq_dispatch
    import lsq_pkg::*;
(
    input  logic       clk,
    input  logic       init,
    input  logic       flush,
    input  logic       ld_valid,
    input  lsq_addr_t  ld_addr,
    output logic       ld_ready,
    input  logic       enq_ready,
    input  lsq_tag_t   enq_tag,
    output logic       enq_valid,
    output lsq_entry_t enq_data,
    output logic       mem_req,
    output lsq_addr_t  mem_addr,
    output lsq_tag_t   mem_tag
);
    // a load is taken whenever the queue has a free slot.
    assign ld_ready  = enq_ready;
    assign enq_valid = ld_valid && enq_ready;

    always_comb begin
        enq_data      = '0;
        enq_data.busy = 1'b1;
        enq_data.addr = ld_addr;
    end

    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            mem_req <= 1'b0;
        end else if (flush) begin
            mem_req <= 1'b0;
        end else begin
            mem_req <= enq_valid;
        end
    end

    // the issue carries the slot tag so completions can find their way back.
    always_ff @(posedge clk) begin
        if (enq_valid) begin
            mem_addr <= ld_addr;
            mem_tag  <= enq_tag;
        end
    end

endmodule

// ==== source/lsq_writeback.sv ====
`timescale 1ns/10ps
`include "lsq_defs.svh"

module lsq_writeback
    import lsq_pkg::*;
(
    input  logic                        cmp_valid,
    input  lsq_tag_t                    cmp_tag,
    input  lsq_data_t                   cmp_data,
    input  lsq_entry_t [`LSQ_DEPTH-1:0] entries,
    output logic [`LSQ_DEPTH-1:0]       wr_en,
    output lsq_entry_t [`LSQ_DEPTH-1:0] wr_data
);
    logic [`LSQ_DEPTH-1:0] tag_hit;
    logic [`LSQ_DEPTH-1:0] slot_open;

    always_comb begin
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            tag_hit[i] = cmp_valid && (cmp_tag == lsq_tag_t'(i));
        end
    end

    // a slot takes data once, and only while it holds a load in flight.
    always_comb begin
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            slot_open[i] = entries[i].busy && !entries[i].done;
        end
    end

    assign wr_en = tag_hit & slot_open;

    always_comb begin
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            wr_data[i]      = entries[i];
            wr_data[i].done = 1'b1;
            wr_data[i].data = cmp_data;
        end
    end

endmodule

// ==== source/lsq_retire.sv ====
`timescale 1ns/10ps

module lsq_retire
    import lsq_pkg::*;
(
    input  logic       clk,
    input  logic       init,
    input  logic       flush,
    input  lsq_entry_t head,
    output logic       deq_valid,
    output logic       out_valid,
    output lsq_addr_t  out_addr,
    output lsq_data_t  out_data
);
    retire_state_t state;
    retire_state_t state_next;

    // the head leaves as soon as its data is back.
    assign deq_valid = head.busy && head.done;
    assign out_valid = (state == emit);

    always_comb begin
        unique case (state)
            idle:    state_next = deq_valid ? emit : idle;
            emit:    state_next = deq_valid ? emit : idle;
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            state <= idle;
        end else if (flush) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (deq_valid) begin
            out_addr <= head.addr;
            out_data <= head.data;
        end
    end

endmodule

// ==== source/lsq_top.sv ====
`timescale 1ns/10ps
`include "lsq_defs.svh"

module lsq_top
    import lsq_pkg::*;
(
    input  logic      clk,
    input  logic      init,
    input  logic      flush,
    input  logic      ld_valid,
    input  lsq_addr_t ld_addr,
    output logic      ld_ready,
    output logic      mem_req,
    output lsq_addr_t mem_addr,
    output lsq_tag_t  mem_tag,
    input  logic      cmp_valid,
    input  lsq_tag_t  cmp_tag,
    input  lsq_data_t cmp_data,
    output logic      out_valid,
    output lsq_addr_t out_addr,
    output lsq_data_t out_data
);
    logic                        enq_valid;
    logic                        enq_ready;
    lsq_entry_t                  enq_data;
    lsq_tag_t                    enq_tag;
    logic                        deq_valid;
    lsq_entry_t                  head;
    logic [`LSQ_DEPTH-1:0]       wr_en;
    lsq_entry_t [`LSQ_DEPTH-1:0] wr_data;
    lsq_entry_t [`LSQ_DEPTH-1:0] entries;

    lsq_dispatch i_dispatch (
        .clk       (clk),
        .init      (init),
        .flush     (flush),
        .ld_valid  (ld_valid),
        .ld_addr   (ld_addr),
        .ld_ready  (ld_ready),
        .enq_ready (enq_ready),
        .enq_tag   (enq_tag),
        .enq_valid (enq_valid),
        .enq_data  (enq_data),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_tag   (mem_tag)
    );

    lsq_queue #(
        .depth (`LSQ_DEPTH)
    ) i_queue (
        .clk       (clk),
        .init      (init),
        .flush     (flush),
        .enq_valid (enq_valid),
        .enq_data  (enq_data),
        .enq_ready (enq_ready),
        .enq_tag   (enq_tag),
        .deq_valid (deq_valid),
        .deq_data  (head),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .entries   (entries)
    );

    lsq_writeback i_writeback (
        .cmp_valid (cmp_valid),
        .cmp_tag   (cmp_tag),
        .cmp_data  (cmp_data),
        .entries   (entries),
        .wr_en     (wr_en),
        .wr_data   (wr_data)
    );

    lsq_retire i_retire (
        .clk       (clk),
        .init      (init),
        .flush     (flush),
        .head      (head),
        .deq_valid (deq_valid),
        .out_valid (out_valid),
        .out_addr  (out_addr),
        .out_data  (out_data)
    );

endmodule

// ==== dv/lsq_props.sv ====
`timescale 1ns/10ps
`include "lsq_defs.svh"

module lsq_props
    import lsq_pkg::*;
(
    input logic     clk,
    input logic     init,
    input logic     flush,
    input logic     ld_valid,
    input logic     ld_ready,
    input logic     mem_req,
    input lsq_tag_t mem_tag,
    input logic     out_valid
);
    int                    errors = 0;
    logic [`LSQ_DEPTH-1:0] pending;

    // tags issued since the last retirement or flush.
    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            pending <= '0;
        end else if (flush) begin
            pending <= '0;
        end else begin
            pending <= (out_valid ? '0 : pending) | ({{(`LSQ_DEPTH-1){1'b0}}, mem_req} << mem_tag);
        end
    end

    no_reissue: assert property (@(posedge clk) disable iff (init)
        mem_req |-> !pending[mem_tag])
        else begin
            errors++;
            $error("tag 0x%h issued again before any retirement or flush", mem_tag);
        end

    quiet_after_init: assert property (@(posedge clk) init |=> !out_valid)
        else begin
            errors++;
            $error("out_valid high in the cycle after init");
        end

    no_accept_when_full: assert property (@(posedge clk) disable iff (init)
        (ld_valid && !ld_ready) |=> !mem_req)
        else begin
            errors++;
            $error("a load was issued although ld_ready was low");
        end

endmodule

bind lsq_top lsq_props i_props (.*);

// ==== dv/lsq_tb.sv ====
`timescale 1ns/10ps
`include "lsq_defs.svh"

module lsq_tb
    import lsq_pkg::*;
();
    localparam int timeout = 40;

    logic      clk, init, flush, ld_valid, ld_ready, mem_req, cmp_valid, out_valid;
    lsq_addr_t ld_addr, mem_addr, out_addr;
    lsq_tag_t  mem_tag, cmp_tag;
    lsq_data_t cmp_data, out_data;

    // model of the queue: tags in program order, with the address and data of each slot.
    integer    seed;
    int        issued;
    lsq_tag_t  order_q[$];
    lsq_addr_t slot_addr[`LSQ_DEPTH];
    lsq_data_t slot_data[`LSQ_DEPTH];

    lsq_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input lsq_addr_t got, input lsq_addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_data(input string name, input lsq_data_t got, input lsq_data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_tag(input string name, input lsq_tag_t got, input lsq_tag_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // inputs change 1 ns after the rising edge.
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // slots are handed out in order, so the tag is the issue count modulo the depth.
    task automatic push_load(input lsq_addr_t addr);
        int       waited;
        lsq_tag_t tag;
        waited = 0;
        while (!ld_ready) begin
            if (waited == timeout) begin
                abort_run("ld_ready stayed low while a load was waiting to enter");
            end
            tick();
            waited++;
        end
        tag      = lsq_tag_t'(issued % `LSQ_DEPTH);
        ld_valid = 1'b1;
        ld_addr  = addr;
        tick();
        ld_valid = 1'b0;
        check_bit("mem_req", mem_req, 1'b1);
        check_addr("mem_addr", mem_addr, addr);
        check_tag("mem_tag", mem_tag, tag);
        slot_addr[tag] = addr;
        order_q.push_back(tag);
        issued++;
    endtask

    task automatic drive_completion(input lsq_tag_t tag, input lsq_data_t data);
        cmp_valid = 1'b1;
        cmp_tag   = tag;
        cmp_data  = data;
        tick();
        cmp_valid = 1'b0;
    endtask

    task automatic complete_load(input lsq_tag_t tag);
        slot_data[tag] = lsq_data_t'($random(seed));
        drive_completion(tag, slot_data[tag]);
    endtask

    // the oldest load in the model must be the next one to come out.
    task automatic expect_out();
        int       waited;
        lsq_tag_t tag;
        if (order_q.size() == 0) begin
            abort_run("a result was expected but no load is outstanding in the model");
        end
        tag    = order_q.pop_front();
        waited = 0;
        while (!out_valid) begin
            if (waited == timeout) begin
                abort_run("out_valid never rose for a load whose data had returned");
            end
            tick();
            waited++;
        end
        check_addr("out_addr", out_addr, slot_addr[tag]);
        check_data("out_data", out_data, slot_data[tag]);
        tick();
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            tick();
            check_bit("out_valid", out_valid, 1'b0);
            check_bit("mem_req", mem_req, 1'b0);
        end
    endtask

    task automatic after_reset_load();
        check_bit("ld_ready", ld_ready, 1'b1);
        check_bit("mem_req", mem_req, 1'b0);
        check_bit("out_valid", out_valid, 1'b0);
        push_load(lsq_addr_t'($random(seed)));
        complete_load(order_q[0]);
        expect_out();
    endtask

    task automatic reverse_completion_order();
        for (int i = 0; i < 4; i++) begin
            push_load(lsq_addr_t'($random(seed)));
        end
        for (int i = 3; i >= 0; i--) begin
            complete_load(order_q[i]);
        end
        repeat (4) begin
            expect_out();
        end
    endtask

    task automatic fill_queue();
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            push_load(lsq_addr_t'($random(seed)));
        end
        check_bit("ld_ready", ld_ready, 1'b0);
        ld_valid = 1'b1;
        ld_addr  = lsq_addr_t'($random(seed));
        repeat (3) begin
            tick();
            check_bit("mem_req", mem_req, 1'b0);
            check_bit("ld_ready", ld_ready, 1'b0);
        end
        ld_valid = 1'b0;
        complete_load(order_q[0]);
        expect_out();
        push_load(lsq_addr_t'($random(seed)));
        while (order_q.size() != 0) begin
            complete_load(order_q[0]);
            expect_out();
        end
    endtask

    task automatic ignore_stray_completions();
        lsq_tag_t second;
        // the completion hits the slot allocated at this same edge, which is still free.
        cmp_valid = 1'b1;
        cmp_tag   = lsq_tag_t'(issued % `LSQ_DEPTH);
        cmp_data  = lsq_data_t'($random(seed));
        push_load(lsq_addr_t'($random(seed)));
        cmp_valid = 1'b0;
        push_load(lsq_addr_t'($random(seed)));
        second = order_q[1];
        complete_load(second);
        drive_completion(second, lsq_data_t'($random(seed)));
        // the head has no data yet, so nothing may retire.
        expect_quiet(3);
        complete_load(order_q[0]);
        repeat (2) begin
            expect_out();
        end
    endtask

    task automatic flush_in_flight();
        repeat (3) begin
            push_load(lsq_addr_t'($random(seed)));
        end
        // the head is ready to retire, so only the flush keeps it from coming out.
        complete_load(order_q[0]);
        flush = 1'b1;
        tick();
        flush = 1'b0;
        order_q.delete();
        issued = 0;
        expect_quiet(8);
        push_load(lsq_addr_t'($random(seed)));
        complete_load(order_q[0]);
        expect_out();
    endtask

    initial begin
        seed      = 32'haaf0;
        issued    = 0;
        init      = 1'b1;
        flush     = 1'b0;
        ld_valid  = 1'b0;
        ld_addr   = '0;
        cmp_valid = 1'b0;
        cmp_tag   = '0;
        cmp_data  = '0;
        repeat (16) @(posedge clk);
        #1;
        init = 1'b0;
        after_reset_load();
        reverse_completion_order();
        fill_queue();
        ignore_stray_completions();
        flush_in_flight();
        if (i_dut.i_props.errors != 0) begin
            abort_run("the bound checker reported failed assertions");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// ==== build.f ====
+incdir+source
source/lsq_pkg.sv
source/lsq_queue.sv
source/lsq_dispatch.sv
source/lsq_writeback.sv
source/lsq_retire.sv
source/lsq_top.sv
dv/lsq_props.sv
dv/lsq_tb.sv

// ==== Bender.yml ====
package:
  name: lsq

sources:
  - include_dirs:
      - source
    files:
      - source/lsq_pkg.sv
      - source/lsq_queue.sv
      - source/lsq_dispatch.sv
      - source/lsq_writeback.sv
      - source/lsq_retire.sv
      - source/lsq_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/lsq_props.sv
      - dv/lsq_tb.sv
